// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := event_bridge_tb
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== cdc_pkg.sv ====
// Crossing constants shared by the level and pulse synchronizers
package cdc_pkg;

    // Number of flops in every level synchronizer chain
    // Two stages give the first flop a full destination cycle to settle
    localparam int sync_stages = 2;

    // Extra destination cycles added to the output pulse
    // Zero gives a pulse one destination cycle wide
    localparam int pulse_length = 0;

endpackage

// ==== cdc_pulse_synchronizer.sv ====
// Pulse crossing from a fast clock into a slow clock with a returned acknowledge
module cdc_pulse_synchronizer
    import cdc_pkg::*;
#(
    parameter int PULSE_LENGTH = pulse_length
) (
    input  logic clock_from,
    input  logic clock_to,
    input  logic rst_n,
    input  logic rst_to_n,
    input  logic pulse_from,
    output logic pulse_to,
    output logic busy
);

    // Level held in the fast domain until the slow domain has seen it
    logic pulse_from_level;
    // Level after crossing into the slow domain
    logic pulse_to_level;
    // The slow-side level brought back to the fast domain
    logic clear_latch;

    // Set on the input pulse and hold until the acknowledge returns
    // An input pulse while the acknowledge is high is lost here
    always_ff @(posedge clock_from) begin
        if (!rst_n) begin
            pulse_from_level <= 1'b0;
        end else if (clear_latch) begin
            pulse_from_level <= 1'b0;
        end else begin
            pulse_from_level <= pulse_from | pulse_from_level;
        end
    end

    // Forward path into the slow clock
    cdc_synchronizer sync_to (
        .clock_to  (clock_to),
        .rst_n     (rst_to_n),
        .data_from (pulse_from_level),
        .data_to   (pulse_to_level)
    );

    // Return path that tells the fast side the level was captured
    cdc_synchronizer sync_from (
        .clock_to  (clock_from),
        .rst_n     (rst_n),
        .data_from (pulse_to_level),
        .data_to   (clear_latch)
    );

    // The slow domain sees one pulse per rising edge of the crossed level
    posedge_pulse_generator #(
        .PULSE_LENGTH (PULSE_LENGTH)
    ) pulse_to_generator (
        .clock     (clock_to),
        .rst_n     (rst_to_n),
        .level_in  (pulse_to_level),
        .pulse_out (pulse_to)
    );

    // Busy covers the pulse being latched, the held latch, and the acknowledge
    // It falls only when the acknowledge has come back low again
    assign busy = pulse_from | pulse_from_level | clear_latch;

endmodule

// ==== cdc_synchronizer.sv ====
// Multi-flop synchronizer that carries a single level into the destination clock
module cdc_synchronizer
    import cdc_pkg::*;
(
    input  logic clock_to,
    input  logic rst_n,
    input  logic data_from,
    output logic data_to
);

    // Shift chain clocked by the destination clock
    // Bit zero is the first flop and may go metastable
    logic [sync_stages-1:0] stages;

    always_ff @(posedge clock_to) begin
        if (!rst_n) begin
            stages <= '0;
        end else begin
            // Each edge moves the level one flop further along
            stages <= {stages[sync_stages-2:0], data_from};
        end
    end

    // Only the last flop is safe to use in the destination domain
    assign data_to = stages[sync_stages-1];

endmodule

// ==== event_bridge_assertions.sv ====
// Concurrent checks on the event bridge ports, bound into the top level
module event_bridge_assertions (
    input logic       clock_from,
    input logic       clock_to,
    input logic       rst_n,
    input logic       event_valid,
    input logic       busy,
    input logic [7:0] drop_count,
    input logic       update
);

    // One failure tally per property
    int update_failures = 0;
    int reset_failures  = 0;
    int drop_failures   = 0;
    int busy_failures   = 0;

    // The slow-side strobe never lasts beyond one clock_to cycle
    update_single: assert property (@(posedge clock_to) disable iff (!rst_n)
        update |=> !update)
        else begin
            $error("update stayed high for two clock_to cycles");
            update_failures++;
        end

    // Nothing is in flight once a reset edge has cleared the crossing
    busy_after_reset: assert property (@(posedge clock_from)
        !rst_n |=> !busy)
        else begin
            $error("busy is high right after a reset edge");
            reset_failures++;
        end

    // The drop counter only climbs or saturates between resets
    drops_rising: assert property (@(posedge clock_from)
        rst_n && $past(rst_n) |-> drop_count >= $past(drop_count))
        else begin
            $error("drop_count went down outside reset");
            drop_failures++;
        end

    // An accepted event makes busy high on the very next fast cycle
    busy_on_accept: assert property (@(posedge clock_from) disable iff (!rst_n)
        event_valid && !busy |=> busy)
        else begin
            $error("busy did not rise after an accepted event");
            busy_failures++;
        end

endmodule

// ==== event_bridge_tb.sv ====
// Directed testbench for the event bridge with a model of the slow-side totals
module event_bridge_tb
    import event_pkg::*;
();

    // An event takes about fifteen clock_from cycles end to end
    // Allowing 24 cycles per event leaves margin for the slowest phase
    // The wrap test alone sends up to 258 events, so 300 events cover the whole run
    localparam int timeout_cycles = 300 * 24;

    logic          clock_from;
    logic          clock_to;
    logic          rst_n;
    logic          event_valid;
    event_word_t   event_word;
    logic          busy;
    logic [7:0]    drop_count;
    tally_status_t status;
    logic          update;

    // Expected totals and fault record, built from the decoding rules
    logic [total_width-1:0] model_totals [num_channels];
    logic [7:0]             model_fault_count;
    logic [7:0]             model_last_code;
    integer                 seed = 32'h3ea8;
    int                     cycle_count = 0;
    int                     update_count = 0;

    tb_clock_gen clocks0 (.*);

    event_bridge_top dut0 (.*);

    bind event_bridge_top event_bridge_assertions checks0 (
        .clock_from  (clock_from),
        .clock_to    (clock_to),
        .rst_n       (rst_n),
        .event_valid (event_valid),
        .busy        (busy),
        .drop_count  (drop_count),
        .update      (update)
    );

    // Watchdog on the fast clock
    always @(posedge clock_from) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d clock_from cycles without reaching the end", cycle_count);
            $display("Checks failed");
            $fatal(1, "Run stopped by the watchdog");
        end
    end

    // Any bound assertion failure ends the run at once
    always @(posedge clock_from) begin
        if (dut0.checks0.update_failures + dut0.checks0.reset_failures
            + dut0.checks0.drop_failures + dut0.checks0.busy_failures != 0) begin
            $display("A bound assertion failed before %0t", $time);
            $display("Checks failed");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    // Counts slow cycles with update high as seen just before each edge
    always @(posedge clock_to) begin
        if (update) begin
            update_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic check_status();
        int         i;
        logic [1:0] ch;
        for (i = 0; i < num_channels; i++) begin
            ch = 2'(i);
            check_value($sformatf("status.totals[%0d]", i), 32'(status.totals[ch]),
                        32'(model_totals[ch]));
        end
        check_value("status.fault_count", 32'(status.fault_count), 32'(model_fault_count));
        check_value("status.last_fault_code", 32'(status.last_fault_code),
                    32'(model_last_code));
    endtask

    // Reserved bits are zero and the channel is ignored for a fault
    function automatic event_word_t make_word(input event_kind_e kind,
                                              input logic [1:0] channel,
                                              input logic [7:0] value);
        event_word_t w;
        w = '0;
        w.kind = kind;
        if (kind == increment) begin
            w.payload.as_increment.channel = channel;
            w.payload.as_increment.amount  = value;
        end else begin
            w.payload.as_fault.code = value;
        end
        return w;
    endfunction

    // Increments wrap at 16 bits and the fault count stops at 255
    task automatic apply_model(input event_word_t w);
        if (w.kind == increment) begin
            model_totals[w.payload.as_increment.channel] +=
                total_width'(w.payload.as_increment.amount);
        end else begin
            if (model_fault_count != 8'hff) begin
                model_fault_count += 8'd1;
            end
            model_last_code = w.payload.as_fault.code;
        end
    endtask

    // Returns on a rising clock_from edge, with busy seen low half a cycle before
    task automatic wait_idle();
        @(negedge clock_from);
        while (busy) begin
            @(negedge clock_from);
        end
        @(posedge clock_from);
    endtask

    // Status is steady at the falling slow edge inside the update cycle
    task automatic wait_update();
        @(negedge clock_to);
        while (!update) begin
            @(negedge clock_to);
        end
    endtask

    task automatic send_event(input event_word_t w);
        wait_idle();
        event_valid <= 1'b1;
        event_word  <= w;
        @(posedge clock_from);
        event_valid <= 1'b0;
        apply_model(w);
        wait_update();
    endtask

    task automatic test_reset_state();
        @(negedge clock_from);
        check_value("busy", 32'(busy), 0);
        check_value("drop_count", 32'(drop_count), 0);
        check_value("update", 32'(update), 0);
        check_status();
    endtask

    task automatic test_increments();
        logic [31:0] r;
        int          i;
        for (i = 0; i < num_channels; i++) begin
            r = $random(seed);
            send_event(make_word(increment, 2'(i), r[7:0]));
            check_status();
        end
    endtask

    task automatic test_wrap();
        int sum;
        sum = int'(model_totals[1]);
        // Keep adding the largest amount until the plain sum passes 65535
        while (sum <= 65535) begin
            send_event(make_word(increment, 2'd1, 8'hff));
            sum += 255;
        end
        check_value("status.totals[1]", 32'(status.totals[1]), sum % 65536);
        check_status();
    endtask

    task automatic test_faults();
        logic [31:0] r;
        logic [7:0]  code;
        code = '0;
        repeat (3) begin
            r    = $random(seed);
            code = r[7:0];
            send_event(make_word(fault, 2'd0, code));
        end
        check_value("status.fault_count", 32'(status.fault_count), 3);
        check_value("status.last_fault_code", 32'(status.last_fault_code), 32'(code));
        check_status();
    endtask

    task automatic test_drops();
        logic [7:0] drops_before;
        int         updates_before;
        int         i;
        wait_idle();
        drops_before   = drop_count;
        updates_before = update_count;
        // Four strobes in a row, only the first one finds the bridge idle
        for (i = 0; i < 4; i++) begin
            event_valid <= 1'b1;
            event_word  <= make_word(increment, 2'(i), 8'(i + 3));
            @(posedge clock_from);
        end
        event_valid <= 1'b0;
        apply_model(make_word(increment, 2'd0, 8'd3));
        wait_update();
        wait_idle();
        repeat (3) @(negedge clock_to);
        check_value("drop_count", 32'(drop_count), 32'(drops_before) + 3);
        check_value("update pulses", update_count - updates_before, 1);
        check_status();
    endtask

    task automatic test_mixed();
        logic [31:0] r;
        logic [7:0]  drops_before;
        drops_before = drop_count;
        repeat (20) begin
            r = $random(seed);
            // Reserved bits are random here too and must not affect the totals
            send_event(event_word_t'(r[15:0]));
            check_status();
        end
        check_value("drop_count", 32'(drop_count), 32'(drops_before));
    endtask

    initial begin
        event_valid       <= 1'b0;
        event_word        <= '0;
        model_totals      = '{default: '0};
        model_fault_count = '0;
        model_last_code   = '0;
        @(posedge rst_n);
        // The slow domain leaves reset two slow edges after the fast one
        repeat (4) @(posedge clock_to);
        test_reset_state();
        test_increments();
        test_wrap();
        test_faults();
        test_drops();
        test_mixed();
        if (dut0.checks0.update_failures + dut0.checks0.reset_failures
            + dut0.checks0.drop_failures + dut0.checks0.busy_failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Bound assertions failed during the run");
        end
    end

endmodule

// ==== event_bridge_top.sv ====
// Event bridge from the fast sender domain into the slow tally domain
module event_bridge_top
    import cdc_pkg::*;
    import event_pkg::*;
(
    input  logic          clock_from,
    input  logic          clock_to,
    input  logic          rst_n,
    input  logic          event_valid,
    input  event_word_t   event_word,
    output logic          busy,
    output logic [7:0]    drop_count,
    output tally_status_t status,
    output logic          update
);

    // Reset as seen by the slow domain
    logic        rst_to_n;
    // Single-cycle strobe for each accepted event
    logic        new_event;
    // One pulse in the slow domain per crossed event
    logic        event_pulse;
    // Word held steady while its crossing is in flight
    event_word_t held_word;

    // Reset enters the slow domain as a level through its own synchronizer
    cdc_synchronizer reset_sync (
        .clock_to  (clock_to),
        .rst_n     (rst_n),
        .data_from (1'b1),
        .data_to   (rst_to_n)
    );

    // Accept events, hold the word, and count drops
    event_latch latch0 (
        .clock_from  (clock_from),
        .rst_n       (rst_n),
        .event_valid (event_valid),
        .event_word  (event_word),
        .busy        (busy),
        .new_event   (new_event),
        .held_word   (held_word),
        .drop_count  (drop_count)
    );

    // Carry the strobe across and report busy back to the sender
    cdc_pulse_synchronizer #(
        .PULSE_LENGTH (pulse_length)
    ) pulse_sync0 (
        .clock_from (clock_from),
        .clock_to   (clock_to),
        .rst_n      (rst_n),
        .rst_to_n   (rst_to_n),
        .pulse_from (new_event),
        .pulse_to   (event_pulse),
        .busy       (busy)
    );

    // Decode the held word in the slow domain
    event_tally tally0 (
        .clock_to    (clock_to),
        .rst_to_n    (rst_to_n),
        .event_pulse (event_pulse),
        .held_word   (held_word),
        .status      (status),
        .update      (update)
    );

endmodule

// ==== event_latch.sv ====
// Fast-side holder of the event word with acceptance gate and drop counter
module event_latch
    import event_pkg::*;
(
    input  logic        clock_from,
    input  logic        rst_n,
    input  logic        event_valid,
    input  event_word_t event_word,
    input  logic        busy,
    output logic        new_event,
    output event_word_t held_word,
    output logic [7:0]  drop_count
);

    // Set for the one cycle between acceptance and the crossing latch rising
    logic pending;
    // Any reason to refuse a new event this cycle
    logic blocked;
    // The event on the inputs is taken this edge
    logic accept;

    assign blocked = busy | pending;
    assign accept  = event_valid & ~blocked;

    always_ff @(posedge clock_from) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    // The pending bit doubles as the strobe into the crossing
    assign new_event = pending;

    // Word stays put until the next accepted event
    // The slow side reads it only while the crossing is busy
    always_ff @(posedge clock_from) begin
        if (accept) begin
            held_word <= event_word;
        end
    end

    // Count refused strobes and stop at the top value
    always_ff @(posedge clock_from) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (event_valid && blocked && (drop_count != 8'hff)) begin
            drop_count <= drop_count + 8'd1;
        end
    end

endmodule

// ==== event_pkg.sv ====
// Event word layout, its two decoded views, and the slow-side status record
package event_pkg;

    // Number of channel totals kept on the slow side
    localparam int num_channels = 4;

    // Width of each channel total, wrapping on overflow
    localparam int total_width = 16;

    // Top bit of the event word says how the payload is read
    typedef enum logic [0:0] {
        increment = 1'b0,
        fault     = 1'b1
    } event_kind_e;

    // Payload seen as a channel increment
    typedef struct packed {
        logic [1:0] channel;
        logic [4:0] reserved;
        logic [7:0] amount;
    } increment_view_t;

    // Payload seen as a fault report
    typedef struct packed {
        logic [6:0] reserved;
        logic [7:0] code;
    } fault_view_t;

    // Both views cover the same 15 payload bits
    typedef union packed {
        increment_view_t as_increment;
        fault_view_t     as_fault;
    } event_payload_u;

    // Full 16-bit event word as the sender drives it
    typedef struct packed {
        event_kind_e    kind;
        event_payload_u payload;
    } event_word_t;

    // Running totals and fault record presented in the slow domain
    typedef struct packed {
        logic [num_channels-1:0][total_width-1:0] totals;
        logic [7:0]                               fault_count;
        logic [7:0]                               last_fault_code;
    } tally_status_t;

endpackage

// ==== event_tally.sv ====
// Slow-side decoder that keeps channel totals and the fault record
module event_tally
    import event_pkg::*;
(
    input  logic          clock_to,
    input  logic          rst_to_n,
    input  logic          event_pulse,
    input  event_word_t   held_word,
    output tally_status_t status,
    output logic          update
);

    // Both readings of the payload
    // The kind field decides which one is meaningful
    increment_view_t incr_view;
    fault_view_t     fault_view;

    assign incr_view  = held_word.payload.as_increment;
    assign fault_view = held_word.payload.as_fault;

    always_ff @(posedge clock_to) begin
        if (!rst_to_n) begin
            status <= '0;
            update <= 1'b0;
        end else begin
            // Status and update move together one cycle after the pulse
            update <= event_pulse;
            if (event_pulse) begin
                case (held_word.kind)
                    increment: begin
                        // Totals wrap at the top of their range
                        status.totals[incr_view.channel] <=
                            status.totals[incr_view.channel] + total_width'(incr_view.amount);
                    end
                    fault: begin
                        // Fault count holds at its top value
                        if (status.fault_count != 8'hff) begin
                            status.fault_count <= status.fault_count + 8'd1;
                        end
                        status.last_fault_code <= fault_view.code;
                    end
                endcase
            end
        end
    end

    // The reserved fields of both views are ignored
    // since neither reading gives them a meaning yet

endmodule

// ==== posedge_pulse_generator.sv ====
// Rising-edge detector that turns a level into a pulse of fixed length
module posedge_pulse_generator #(
    parameter int PULSE_LENGTH = 0
) (
    input  logic clock,
    input  logic rst_n,
    input  logic level_in,
    output logic pulse_out
);

    // The counter must hold PULSE_LENGTH and never be zero bits wide
    localparam int count_width = (PULSE_LENGTH > 0) ? $clog2(PULSE_LENGTH + 1) : 1;

    logic                   level_q;
    logic                   rising;
    logic [count_width-1:0] count;

    // An edge is a high level this cycle after a low one the cycle before
    assign rising = level_in & ~level_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            level_q   <= 1'b0;
            pulse_out <= 1'b0;
            count     <= '0;
        end else begin
            level_q <= level_in;
            if (rising) begin
                // Start the pulse and load the cycles still to hold it
                pulse_out <= 1'b1;
                count     <= count_width'(PULSE_LENGTH);
            end else if (count != '0) begin
                // Hold the pulse while the counter runs down
                count <= count - 1'b1;
            end else begin
                pulse_out <= 1'b0;
            end
        end
    end

    // A new edge during a pulse restarts the count
    // so the pulse is stretched rather than split in two

endmodule

// ==== src.f ====
cdc_pkg.sv
event_pkg.sv
cdc_synchronizer.sv
posedge_pulse_generator.sv
cdc_pulse_synchronizer.sv
event_latch.sv
event_tally.sv
event_bridge_top.sv
tb_clock_gen.sv
event_bridge_assertions.sv
event_bridge_tb.sv

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source for the fast sender and slow tally domains
module tb_clock_gen (
    output logic clock_from,
    output logic clock_to,
    output logic rst_n
);

    // Fast sender clock with a period of 8
    initial begin
        clock_from = 1'b0;
        forever #4 clock_from = ~clock_from;
    end

    // Slow tally clock with a period of 20
    // Its rising edges never line up with the fast ones
    initial begin
        clock_to = 1'b0;
        forever #10 clock_to = ~clock_to;
    end

    // Reset is held for five slow cycles and released on a slow edge
    initial begin
        rst_n <= 1'b0;
        repeat (5) @(posedge clock_to);
        rst_n <= 1'b1;
    end

endmodule
